//--- rtl/bypass_defs.svh
`ifndef BYPASS_DEFS_SVH
`define BYPASS_DEFS_SVH

////////////////////////////////////////////////////////////
// datapath sizes
////////////////////////////////////////////////////////////

// width of one architectural register
`define XLEN 32

// register index width
`define REG_ADDR_W 5

// depth of the architectural register file
`define REG_COUNT 32

// one enable bit per byte lane of a word
`define BYTE_EN_W (`XLEN / 8)

`endif

//--- rtl/bypassPkg.sv
`default_nettype none

`include "bypass_defs.svh"

package bypassPkg;

	////////////////////////////////////////////////////////////
	// shared datapath types
	////////////////////////////////////////////////////////////

	// one register value
	typedef logic [`XLEN-1:0] wordT;

	// register file index
	typedef logic [`REG_ADDR_W-1:0] regAddrT;

	// mem stage byte lane enable, one-hot for byte loads
	typedef logic [`BYTE_EN_W-1:0] byteEnT;

endpackage

`default_nettype wire

//--- rtl/stageBus.sv
`timescale 1ns/1ps
`default_nettype none

// one stage's pending register write, already cleaned
interface stageBus
	import bypassPkg::*;
();

	regAddrT wrAddr;
	wordT    wrData;
	logic    wrEn;
	// data already produced by this stage
	logic    dataValid;

	modport producer (
		output wrAddr,
		output wrData,
		output wrEn,
		output dataValid
	);

	modport consumer (
		input wrAddr,
		input wrData,
		input wrEn,
		input dataValid
	);

endinterface

`default_nettype wire

//--- rtl/bypassCollect.sv
`timescale 1ns/1ps
`default_nettype none

`include "bypass_defs.svh"

module bypassCollect
	import bypassPkg::*;
(
	// exe stage
	input  regAddrT exeWrAddr,
	input  wordT    exeAluResult,
	input  logic    exeDataValid,
	input  logic    exeWrEn,

	// mem stage
	input  regAddrT memWrAddr,
	input  wordT    memReadData,
	input  byteEnT  memByteEn,
	input  logic    memByteLoad,
	input  logic    memDataValid,
	input  logic    memWrEn,

	// wb stage
	input  regAddrT wbWrAddr,
	input  wordT    wbWrData,
	input  logic    wbDataValid,
	input  logic    wbWrEn,

	stageBus.producer exeBus,
	stageBus.producer memBus,
	stageBus.producer wbBus
);

	logic exeToZero;
	logic memToZero;
	logic wbToZero;
	wordT memLoadData;

	function automatic wordT signExtByte(input logic [7:0] loadByte);
		return {{(`XLEN - 8){loadByte[7]}}, loadByte};
	endfunction

	////////////////////////////////////////////////////////////
	// mem load data
	////////////////////////////////////////////////////////////

	// byte loads pick the lane named by the one-hot enable
	always_comb
	begin
		if (memByteLoad)
		begin
			case (memByteEn)
				4'b0001: memLoadData = signExtByte(memReadData[7:0]);
				4'b0010: memLoadData = signExtByte(memReadData[15:8]);
				4'b0100: memLoadData = signExtByte(memReadData[23:16]);
				4'b1000: memLoadData = signExtByte(memReadData[31:24]);
				// malformed enable, nothing sensible to forward
				default: memLoadData = '0;
			endcase
		end
		else
		begin
			memLoadData = memReadData;
		end
	end

	////////////////////////////////////////////////////////////
	// register 0 filtering
	////////////////////////////////////////////////////////////

	// x0 is hardwired, so a write to it is no write at all
	assign exeToZero = (exeWrAddr == '0);
	assign memToZero = (memWrAddr == '0);
	assign wbToZero  = (wbWrAddr == '0);

	assign exeBus.wrAddr    = exeWrAddr;
	assign exeBus.wrData    = exeToZero ? '0 : exeAluResult;
	assign exeBus.wrEn      = exeWrEn && !exeToZero;
	assign exeBus.dataValid = exeDataValid;

	assign memBus.wrAddr    = memWrAddr;
	assign memBus.wrData    = memToZero ? '0 : memLoadData;
	assign memBus.wrEn      = memWrEn && !memToZero;
	assign memBus.dataValid = memDataValid;

	assign wbBus.wrAddr     = wbWrAddr;
	assign wbBus.wrData     = wbToZero ? '0 : wbWrData;
	assign wbBus.wrEn       = wbWrEn && !wbToZero;
	assign wbBus.dataValid  = wbDataValid;

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "bypass_defs.svh"

module regFile
	import bypassPkg::*;
(
	input  logic    clk,
	input  logic    rstN,

	// write port, fed by the cleaned wb record
	stageBus.consumer wb,

	// two combinational read ports
	input  regAddrT rdAddrA,
	input  regAddrT rdAddrB,
	output wordT    rdDataA,
	output wordT    rdDataB
);

	wordT regs [`REG_COUNT];

	////////////////////////////////////////////////////////////
	// write port
	////////////////////////////////////////////////////////////

	// x0 stays zero since the collector never enables a write to it
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wb.wrEn)
		begin
			regs[wb.wrAddr] <= wb.wrData;
		end
	end

	////////////////////////////////////////////////////////////
	// read ports
	////////////////////////////////////////////////////////////

	// no internal write-through, the wb bypass covers same-cycle reads
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

//--- rtl/operandSelect.sv
`timescale 1ns/1ps
`default_nettype none

module operandSelect
	import bypassPkg::*;
(
	input  regAddrT srcAddr,

	// pending writes, youngest first
	stageBus.consumer exe,
	stageBus.consumer mem,
	stageBus.consumer wb,

	input  wordT    rfData,
	output wordT    operand,
	output logic    hazard
);

	logic exeHit;
	logic memHit;
	logic wbHit;

	// enables are already clear for x0, so no zero test here
	assign exeHit = exe.wrEn && (exe.wrAddr == srcAddr);
	assign memHit = mem.wrEn && (mem.wrAddr == srcAddr);
	assign wbHit  = wb.wrEn && (wb.wrAddr == srcAddr);

	////////////////////////////////////////////////////////////
	// forwarding mux
	////////////////////////////////////////////////////////////

	// youngest match wins
	// hazard when that stage has not produced its value yet
	always_comb
	begin
		operand = rfData;
		hazard  = 1'b0;
		if (exeHit)
		begin
			operand = exe.wrData;
			hazard  = !exe.dataValid;
		end
		else if (memHit)
		begin
			operand = mem.wrData;
			hazard  = !mem.dataValid;
		end
		else if (wbHit)
		begin
			operand = wb.wrData;
			hazard  = !wb.dataValid;
		end
	end

endmodule

`default_nettype wire

//--- rtl/bypassUnit.sv
`timescale 1ns/1ps
`default_nettype none

module bypassUnit
	import bypassPkg::*;
(
	input  logic    clk,
	input  logic    rstN,

	// exe stage
	input  regAddrT exeWrAddr,
	input  wordT    exeAluResult,
	input  logic    exeDataValid,
	input  logic    exeWrEn,

	// mem stage
	input  regAddrT memWrAddr,
	input  wordT    memReadData,
	input  byteEnT  memByteEn,
	input  logic    memByteLoad,
	input  logic    memDataValid,
	input  logic    memWrEn,

	// wb stage
	input  regAddrT wbWrAddr,
	input  wordT    wbWrData,
	input  logic    wbDataValid,
	input  logic    wbWrEn,

	// id stage sources
	input  regAddrT rs1Addr,
	input  regAddrT rs2Addr,
	output wordT    rs1Data,
	output wordT    rs2Data,
	output logic    stall
);

	wordT rfData1;
	wordT rfData2;
	logic hazard1;
	logic hazard2;

	stageBus exeBus ();
	stageBus memBus ();
	stageBus wbBus ();

	////////////////////////////////////////////////////////////
	// stage records and architectural state
	////////////////////////////////////////////////////////////

	bypassCollect collect (
		.exeWrAddr    (exeWrAddr),
		.exeAluResult (exeAluResult),
		.exeDataValid (exeDataValid),
		.exeWrEn      (exeWrEn),
		.memWrAddr    (memWrAddr),
		.memReadData  (memReadData),
		.memByteEn    (memByteEn),
		.memByteLoad  (memByteLoad),
		.memDataValid (memDataValid),
		.memWrEn      (memWrEn),
		.wbWrAddr     (wbWrAddr),
		.wbWrData     (wbWrData),
		.wbDataValid  (wbDataValid),
		.wbWrEn       (wbWrEn),
		.exeBus       (exeBus.producer),
		.memBus       (memBus.producer),
		.wbBus        (wbBus.producer)
	);

	regFile rf (
		.clk     (clk),
		.rstN    (rstN),
		.wb      (wbBus.consumer),
		.rdAddrA (rs1Addr),
		.rdAddrB (rs2Addr),
		.rdDataA (rfData1),
		.rdDataB (rfData2)
	);

	////////////////////////////////////////////////////////////
	// operand selection, one per source
	////////////////////////////////////////////////////////////

	operandSelect opSel1 (
		.srcAddr (rs1Addr),
		.exe     (exeBus.consumer),
		.mem     (memBus.consumer),
		.wb      (wbBus.consumer),
		.rfData  (rfData1),
		.operand (rs1Data),
		.hazard  (hazard1)
	);

	operandSelect opSel2 (
		.srcAddr (rs2Addr),
		.exe     (exeBus.consumer),
		.mem     (memBus.consumer),
		.wb      (wbBus.consumer),
		.rfData  (rfData2),
		.operand (rs2Data),
		.hazard  (hazard2)
	);

	// load-use on either source holds id
	assign stall = hazard1 | hazard2;

endmodule

`default_nettype wire

//--- bench/bypassCheck.sv
`timescale 1ns/1ps
`default_nettype none

`include "bypass_defs.svh"

module bypassCheck
	import bypassPkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	// stage records as the DUT sees them
	input  regAddrT exeWrAddr, memWrAddr, wbWrAddr,
	input  wordT    exeAluResult, memReadData, wbWrData,
	input  logic    exeWrEn, memWrEn, wbWrEn,
	input  logic    exeDataValid, memDataValid, wbDataValid,
	input  byteEnT  memByteEn,
	input  logic    memByteLoad,
	// id sources and DUT results
	input  regAddrT rs1Addr, rs2Addr,
	input  wordT    rs1Data, rs2Data,
	input  logic    stall,
	output logic    armed,
	output int      checkCount, valueErrors, stallErrors
);

	// architectural state as it should be
	wordT shadow [`REG_COUNT];

	// mem stage result as a later instruction would see it
	function automatic wordT loadValue();
		wordT shifted;
		wordT result;
		result = memReadData;
		if (memByteLoad)
		begin
			result = '0;
			for (int lane = 0; lane < 4; lane++)
			begin
				if (memByteEn == byteEnT'(1 << lane))
				begin
					// lane to the top, then arithmetic shift back down
					shifted = memReadData << (8 * (3 - lane));
					result  = $signed(shifted) >>> 24;
				end
			end
		end
		return result;
	endfunction

	// {hazard, operand} for one source, youngest stage applied last
	function automatic logic [`XLEN:0] expectedSource(input regAddrT src);
		wordT value;
		logic hazard;
		value  = shadow[src];
		hazard = 1'b0;
		if (src != '0)
		begin
			if (wbWrEn && wbWrAddr == src)
			begin
				value  = wbWrData;
				hazard = !wbDataValid;
			end
			if (memWrEn && memWrAddr == src)
			begin
				value  = loadValue();
				hazard = !memDataValid;
			end
			if (exeWrEn && exeWrAddr == src)
			begin
				value  = exeAluResult;
				hazard = !exeDataValid;
			end
		end
		return {hazard, value};
	endfunction

	function automatic int reportMismatch(input string name, input wordT expected,
		input wordT actual);
		if (expected !== actual)
		begin
			$display("** Error %s at %0t: expected %h, actual %h", name, $time, expected, actual);
			return 1;
		end
		return 0;
	endfunction

	////////////////////////////////////////////////////////////
	// compare, then follow the wb write
	////////////////////////////////////////////////////////////

	always @(posedge clk or negedge rstN)
	begin
		logic [`XLEN:0] expected1;
		logic [`XLEN:0] expected2;
		int valueMiss;
		int stallMiss;
		if (!rstN)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
			begin
				shadow[i] <= '0;
			end
			armed       <= 1'b0;
			checkCount  <= 0;
			valueErrors <= 0;
			stallErrors <= 0;
		end
		else
		begin
			expected1 = expectedSource(rs1Addr);
			expected2 = expectedSource(rs2Addr);
			valueMiss = reportMismatch("rs1Data", expected1[`XLEN-1:0], rs1Data);
			valueMiss = valueMiss + reportMismatch("rs2Data", expected2[`XLEN-1:0], rs2Data);
			stallMiss = reportMismatch("stall", wordT'(expected1[`XLEN] | expected2[`XLEN]),
				wordT'(stall));
			// register file takes the wb write at this edge
			if (wbWrEn && wbWrAddr != '0)
			begin
				shadow[wbWrAddr] <= wbWrData;
			end
			armed       <= 1'b1;
			checkCount  <= checkCount + 1;
			valueErrors <= valueErrors + valueMiss;
			stallErrors <= stallErrors + stallMiss;
		end
	end

endmodule

`default_nettype wire

//--- bench/bypass_properties.sv
`timescale 1ns/1ps
`default_nettype none

module bypassProperties
	import bypassPkg::*;
(
	input logic    clk,
	input logic    rstN,
	input logic    exeWrEn, memWrEn, wbWrEn,
	input regAddrT rs1Addr, rs2Addr,
	input wordT    rs1Data, rs2Data,
	input logic    stall
);

	int resetFails = 0;
	int causeFails = 0;
	int zeroFails1 = 0;
	int zeroFails2 = 0;
	int assertFails;

	// failures over all properties
	assign assertFails = resetFails + causeFails + zeroFails1 + zeroFails2;

	resetQuiet: assert property (@(posedge clk) !rstN |-> !stall)
	else
	begin
		resetFails++;
		$error("stall raised while reset is asserted");
	end

	// a hazard needs a pending write somewhere
	stallCause: assert property (@(posedge clk) stall |-> (exeWrEn || memWrEn || wbWrEn))
	else
	begin
		causeFails++;
		$error("stall raised with no stage write enable set");
	end

	rs1Zero: assert property (@(posedge clk) disable iff (!rstN)
		(rs1Addr == '0) |-> (rs1Data == '0))
	else
	begin
		zeroFails1++;
		$error("rs1Data not zero for register 0");
	end

	rs2Zero: assert property (@(posedge clk) disable iff (!rstN)
		(rs2Addr == '0) |-> (rs2Data == '0))
	else
	begin
		zeroFails2++;
		$error("rs2Data not zero for register 0");
	end

endmodule

bind bypassUnit bypassProperties props (
	.clk     (clk),
	.rstN    (rstN),
	.exeWrEn (exeWrEn),
	.memWrEn (memWrEn),
	.wbWrEn  (wbWrEn),
	.rs1Addr (rs1Addr),
	.rs2Addr (rs2Addr),
	.rs1Data (rs1Data),
	.rs2Data (rs2Data),
	.stall   (stall)
);

`default_nettype wire

//--- bench/bypassTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bypass_defs.svh"

module bypassTb
	import bypassPkg::*;
();

	localparam int HALF_PERIOD   = 20;
	localparam int RESET_CYCLES  = 3;
	localparam int RANDOM_CYCLES = 400;
	localparam int WAIT_LIMIT    = 50;

	logic    clk;
	logic    rstN;
	regAddrT exeWrAddr, memWrAddr, wbWrAddr;
	wordT    exeAluResult, memReadData, wbWrData;
	logic    exeWrEn, memWrEn, wbWrEn;
	logic    exeDataValid, memDataValid, wbDataValid;
	byteEnT  memByteEn;
	logic    memByteLoad;
	regAddrT rs1Addr, rs2Addr;
	wordT    rs1Data, rs2Data;
	logic    stall;
	logic    armed;
	int      checkCount, valueErrors, stallErrors;

	logic [31:0] lfsrState;
	logic        timedOut;
	int          waitCount;
	int          target;

	bypassUnit UUT (.*);
	bypassCheck check (.*);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#HALF_PERIOD clk = ~clk;
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	// galois lfsr, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		if (state[0])
		begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			bits      = {bits[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
		return bits;
	endfunction

	// addresses kept to 0..3 so stages collide often
	task automatic driveStages(input logic allowWrites);
		exeWrAddr    = regAddrT'(takeBits(2));
		exeAluResult = takeBits(32);
		exeDataValid = 1'(takeBits(1));
		exeWrEn      = allowWrites & 1'(takeBits(1));
		memWrAddr    = regAddrT'(takeBits(2));
		memReadData  = takeBits(32);
		memByteEn    = byteEnT'(takeBits(4));
		memByteLoad  = 1'(takeBits(1));
		memDataValid = 1'(takeBits(1));
		memWrEn      = allowWrites & 1'(takeBits(1));
		wbWrAddr     = regAddrT'(takeBits(2));
		wbWrData     = takeBits(32);
		wbDataValid  = 1'(takeBits(1));
		wbWrEn       = allowWrites & 1'(takeBits(1));
		rs1Addr      = regAddrT'(takeBits(2));
		rs2Addr      = regAddrT'(takeBits(2));
	endtask

	initial
	begin
		lfsrState = 32'd75519;
		timedOut  = 1'b0;
		rstN      = 1'b0;
		driveStages(1'b0);
		repeat (RESET_CYCLES) @(negedge clk);
		rstN = 1'b1;

		// checker arms on its first edge out of reset
		waitCount = 0;
		while (armed !== 1'b1 && !timedOut)
		begin
			@(posedge clk);
			waitCount++;
			if (waitCount > WAIT_LIMIT)
			begin
				$display("timeout: checker never came out of reset");
				timedOut = 1'b1;
			end
		end

		if (!timedOut)
		begin
			// every register reads zero straight after reset
			for (int i = 0; i < `REG_COUNT; i++)
			begin
				@(negedge clk);
				driveStages(1'b0);
				rs1Addr = regAddrT'(i);
				rs2Addr = regAddrT'(`REG_COUNT - 1 - i);
			end
			repeat (RANDOM_CYCLES)
			begin
				@(negedge clk);
				driveStages(1'b1);
			end
			@(negedge clk);
			driveStages(1'b0);
			target    = checkCount + 1;
			waitCount = 0;
			while (checkCount < target && !timedOut)
			begin
				@(posedge clk);
				waitCount++;
				if (waitCount > WAIT_LIMIT)
				begin
					$display("timeout: checker stopped comparing before the last vector");
					timedOut = 1'b1;
				end
			end
		end

		$display("checks %0d, value errors %0d, stall errors %0d, assertion failures %0d",
			checkCount, valueErrors, stallErrors, UUT.props.assertFails);
		if (timedOut || valueErrors != 0 || stallErrors != 0 || UUT.props.assertFails != 0)
		begin
			$display("*** TEST FAILED ***");
		end
		else
		begin
			$display("*** TEST PASSED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/bypassPkg.sv
rtl/stageBus.sv
rtl/bypassCollect.sv
rtl/regFile.sv
rtl/operandSelect.sv
rtl/bypassUnit.sv
bench/bypassCheck.sv
bench/bypass_properties.sv
bench/bypassTb.sv

//--- Makefile
TOP := bypassTb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --assert --timescale 1ns/1ps -f src.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^\*\*\* TEST PASSED \*\*\*$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
